//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_memory_subsystem
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG = === PASS ===
FAIL_MSG = === FAIL ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG) || ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/bank_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter (
	input  wire                             CLK,
	input  wire                             RSTb,
	input  wire  [mem_pkg::NUM_CLIENTS-1:0] hit,
	input  wire  [mem_pkg::ADDR_W-1:0]      sp_addr,
	input  wire  [mem_pkg::ADDR_W-1:0]      bg_addr,
	input  wire  [mem_pkg::ADDR_W-1:0]      fl_addr,
	input  wire  [mem_pkg::ADDR_W-1:0]      cpu_addr,
	input  wire  [mem_pkg::DATA_W-1:0]      fl_wdata,
	input  wire  [mem_pkg::DATA_W-1:0]      cpu_wdata,
	input  wire                             cpu_wr,
	output logic [mem_pkg::BANK_ADDR_W-1:0] ram_addr,
	output logic [mem_pkg::DATA_W-1:0]      ram_din,
	output logic                            ram_wr,
	output logic [mem_pkg::NUM_CLIENTS-1:0] grant
);

	mem_pkg::bank_state_e state;
	mem_pkg::bank_state_e state_next;

	// client that owns the RAM port this cycle
	mem_pkg::client_e sel;
	// sel is really requesting (new pick or hit still held)
	logic active;
	logic [mem_pkg::ADDR_W-1:0] sel_addr;

	always_comb begin
		sel = mem_pkg::CL_SPRITE;
		active = 1'b0;
		case (state)
			mem_pkg::ST_IDLE: begin
				active = |hit;
				// fixed priority pick
				if (hit[mem_pkg::CL_SPRITE]) begin
					sel = mem_pkg::CL_SPRITE;
				end else if (hit[mem_pkg::CL_BG]) begin
					sel = mem_pkg::CL_BG;
				end else if (hit[mem_pkg::CL_FLASH]) begin
					sel = mem_pkg::CL_FLASH;
				end else if (hit[mem_pkg::CL_CPU]) begin
					sel = mem_pkg::CL_CPU;
				end
			end
			mem_pkg::ST_GRANT_SP: begin
				sel = mem_pkg::CL_SPRITE;
				active = hit[mem_pkg::CL_SPRITE];
			end
			mem_pkg::ST_GRANT_BG: begin
				sel = mem_pkg::CL_BG;
				active = hit[mem_pkg::CL_BG];
			end
			mem_pkg::ST_GRANT_FL: begin
				sel = mem_pkg::CL_FLASH;
				active = hit[mem_pkg::CL_FLASH];
			end
			mem_pkg::ST_GRANT_CPU: begin
				sel = mem_pkg::CL_CPU;
				active = hit[mem_pkg::CL_CPU];
			end
			default: begin
				sel = mem_pkg::CL_SPRITE;
				active = 1'b0;
			end
		endcase
	end

	// RAM port follows the selected client
	always_comb begin
		case (sel)
			mem_pkg::CL_SPRITE: sel_addr = sp_addr;
			mem_pkg::CL_BG:     sel_addr = bg_addr;
			mem_pkg::CL_FLASH:  sel_addr = fl_addr;
			default:            sel_addr = cpu_addr;
		endcase
	end

	assign ram_addr = sel_addr[mem_pkg::BANK_ADDR_W-1:0];
	assign ram_din = (sel == mem_pkg::CL_CPU) ? cpu_wdata : fl_wdata;

	// flash always writes, cpu on cpu_wr, fetchers never
	// wr drops in the cycle the hit falls
	always_comb begin
		case (sel)
			mem_pkg::CL_FLASH: ram_wr = active;
			mem_pkg::CL_CPU:   ram_wr = active & cpu_wr;
			default:           ram_wr = 1'b0;
		endcase
	end

	always_comb begin
		state_next = state;
		case (state)
			mem_pkg::ST_IDLE: begin
				if (active) begin
					case (sel)
						mem_pkg::CL_SPRITE: state_next = mem_pkg::ST_GRANT_SP;
						mem_pkg::CL_BG:     state_next = mem_pkg::ST_GRANT_BG;
						mem_pkg::CL_FLASH:  state_next = mem_pkg::ST_GRANT_FL;
						default:            state_next = mem_pkg::ST_GRANT_CPU;
					endcase
				end
			end
			mem_pkg::ST_GRANT_SP,
			mem_pkg::ST_GRANT_BG,
			mem_pkg::ST_GRANT_FL,
			mem_pkg::ST_GRANT_CPU: begin
				// client released req
				if (!active) begin
					state_next = mem_pkg::ST_IDLE;
				end
			end
			default: state_next = mem_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= mem_pkg::ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// grant straight from state, so ack trails req by one cycle
	always_comb begin
		grant = '0;
		case (state)
			mem_pkg::ST_GRANT_SP:  grant[mem_pkg::CL_SPRITE] = 1'b1;
			mem_pkg::ST_GRANT_BG:  grant[mem_pkg::CL_BG] = 1'b1;
			mem_pkg::ST_GRANT_FL:  grant[mem_pkg::CL_FLASH] = 1'b1;
			mem_pkg::ST_GRANT_CPU: grant[mem_pkg::CL_CPU] = 1'b1;
			default:               grant = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/bank_ram.sv
`timescale 1ns/1ps
`default_nettype none

module bank_ram (
	input  wire                             CLK,
	input  wire  [mem_pkg::BANK_ADDR_W-1:0] addr,
	input  wire  [mem_pkg::DATA_W-1:0]      din,
	input  wire                             wr,
	output logic [mem_pkg::DATA_W-1:0]      dout
);

	logic [mem_pkg::DATA_W-1:0] mem [0:(1 << mem_pkg::BANK_ADDR_W)-1];

	// cleared contents for simulation
	initial begin
		for (int i = 0; i < (1 << mem_pkg::BANK_ADDR_W); i++) begin
			mem[i] = '0;
		end
	end

	// dout shows the old word on a write cycle
	always_ff @(posedge CLK) begin
		if (wr) begin
			mem[addr] <= din;
		end
		dout <= mem[addr];
	end

endmodule

`default_nettype wire

//--- hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// word address as seen by a client
	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;

	// word address inside one bank
	localparam int BANK_ADDR_W = 14;

	// top two address bits pick the bank
	localparam int NUM_BANKS = 4;
	localparam int NUM_CLIENTS = 4;

	// priority order with the highest first
	// also the bit index into hit and grant vectors
	typedef enum logic [1:0] {
		CL_SPRITE = 2'd0,
		CL_BG     = 2'd1,
		CL_FLASH  = 2'd2,
		CL_CPU    = 2'd3
	} client_e;

	// per-bank arbiter state, one grant state per client
	typedef enum logic [2:0] {
		ST_IDLE      = 3'd0,
		ST_GRANT_SP  = 3'd1,
		ST_GRANT_BG  = 3'd2,
		ST_GRANT_FL  = 3'd3,
		ST_GRANT_CPU = 3'd4
	} bank_state_e;

endpackage

`default_nettype wire

//--- hdl/memory_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memory_arbiter (
	input  wire                             CLK,
	input  wire                             RSTb,

	input  wire                             sp_req,
	input  wire  [mem_pkg::ADDR_W-1:0]      sp_addr,
	output logic [mem_pkg::DATA_W-1:0]      sp_rdata,
	output logic                            sp_ack,

	input  wire                             bg_req,
	input  wire  [mem_pkg::ADDR_W-1:0]      bg_addr,
	output logic [mem_pkg::DATA_W-1:0]      bg_rdata,
	output logic                            bg_ack,

	input  wire                             fl_req,
	input  wire  [mem_pkg::ADDR_W-1:0]      fl_addr,
	input  wire  [mem_pkg::DATA_W-1:0]      fl_wdata,
	output logic                            fl_ack,

	input  wire                             cpu_req,
	input  wire                             cpu_wr,
	input  wire  [mem_pkg::ADDR_W-1:0]      cpu_addr,
	input  wire  [mem_pkg::DATA_W-1:0]      cpu_wdata,
	output logic [mem_pkg::DATA_W-1:0]      cpu_rdata,
	output logic                            cpu_ack,

	output logic [mem_pkg::BANK_ADDR_W-1:0] b1_addr,
	output logic [mem_pkg::DATA_W-1:0]      b1_din,
	output logic                            b1_wr,
	input  wire  [mem_pkg::DATA_W-1:0]      b1_dout,

	output logic [mem_pkg::BANK_ADDR_W-1:0] b2_addr,
	output logic [mem_pkg::DATA_W-1:0]      b2_din,
	output logic                            b2_wr,
	input  wire  [mem_pkg::DATA_W-1:0]      b2_dout,

	output logic [mem_pkg::BANK_ADDR_W-1:0] b3_addr,
	output logic [mem_pkg::DATA_W-1:0]      b3_din,
	output logic                            b3_wr,
	input  wire  [mem_pkg::DATA_W-1:0]      b3_dout,

	output logic [mem_pkg::BANK_ADDR_W-1:0] b4_addr,
	output logic [mem_pkg::DATA_W-1:0]      b4_din,
	output logic                            b4_wr,
	input  wire  [mem_pkg::DATA_W-1:0]      b4_dout
);

	localparam logic [mem_pkg::NUM_BANKS-1:0] ONE = {{(mem_pkg::NUM_BANKS-1){1'b0}}, 1'b1};

	// one-hot bank of each client from addr[15:14]
	logic [mem_pkg::NUM_BANKS-1:0] sp_bank;
	logic [mem_pkg::NUM_BANKS-1:0] bg_bank;
	logic [mem_pkg::NUM_BANKS-1:0] fl_bank;
	logic [mem_pkg::NUM_BANKS-1:0] cpu_bank;

	logic [mem_pkg::NUM_CLIENTS-1:0] hit [mem_pkg::NUM_BANKS];
	logic [mem_pkg::NUM_CLIENTS-1:0] grant [mem_pkg::NUM_BANKS];
	logic [mem_pkg::BANK_ADDR_W-1:0] bank_addr [mem_pkg::NUM_BANKS];
	logic [mem_pkg::DATA_W-1:0] bank_din [mem_pkg::NUM_BANKS];
	logic bank_wr [mem_pkg::NUM_BANKS];
	logic [mem_pkg::DATA_W-1:0] bank_dout [mem_pkg::NUM_BANKS];

	assign sp_bank = ONE << sp_addr[mem_pkg::ADDR_W-1:mem_pkg::BANK_ADDR_W];
	assign bg_bank = ONE << bg_addr[mem_pkg::ADDR_W-1:mem_pkg::BANK_ADDR_W];
	assign fl_bank = ONE << fl_addr[mem_pkg::ADDR_W-1:mem_pkg::BANK_ADDR_W];
	assign cpu_bank = ONE << cpu_addr[mem_pkg::ADDR_W-1:mem_pkg::BANK_ADDR_W];

	for (genvar g = 0; g < mem_pkg::NUM_BANKS; g++) begin : g_bank
		assign hit[g][mem_pkg::CL_SPRITE] = sp_req & sp_bank[g];
		assign hit[g][mem_pkg::CL_BG] = bg_req & bg_bank[g];
		assign hit[g][mem_pkg::CL_FLASH] = fl_req & fl_bank[g];
		assign hit[g][mem_pkg::CL_CPU] = cpu_req & cpu_bank[g];

		bank_arbiter bank_arbiter_inst (
			.CLK       (CLK),
			.RSTb      (RSTb),
			.hit       (hit[g]),
			.sp_addr   (sp_addr),
			.bg_addr   (bg_addr),
			.fl_addr   (fl_addr),
			.cpu_addr  (cpu_addr),
			.fl_wdata  (fl_wdata),
			.cpu_wdata (cpu_wdata),
			.cpu_wr    (cpu_wr),
			.ram_addr  (bank_addr[g]),
			.ram_din   (bank_din[g]),
			.ram_wr    (bank_wr[g]),
			.grant     (grant[g])
		);
	end

	assign b1_addr = bank_addr[0];
	assign b1_din = bank_din[0];
	assign b1_wr = bank_wr[0];
	assign b2_addr = bank_addr[1];
	assign b2_din = bank_din[1];
	assign b2_wr = bank_wr[1];
	assign b3_addr = bank_addr[2];
	assign b3_din = bank_din[2];
	assign b3_wr = bank_wr[2];
	assign b4_addr = bank_addr[3];
	assign b4_din = bank_din[3];
	assign b4_wr = bank_wr[3];

	assign bank_dout[0] = b1_dout;
	assign bank_dout[1] = b2_dout;
	assign bank_dout[2] = b3_dout;
	assign bank_dout[3] = b4_dout;

	// at most one bank grants a client, so OR works as the mux
	// and leaves zero when nothing is granted
	always_comb begin
		sp_ack = 1'b0;
		bg_ack = 1'b0;
		fl_ack = 1'b0;
		cpu_ack = 1'b0;
		sp_rdata = '0;
		bg_rdata = '0;
		cpu_rdata = '0;
		for (int b = 0; b < mem_pkg::NUM_BANKS; b++) begin
			sp_ack = sp_ack | grant[b][mem_pkg::CL_SPRITE];
			bg_ack = bg_ack | grant[b][mem_pkg::CL_BG];
			fl_ack = fl_ack | grant[b][mem_pkg::CL_FLASH];
			cpu_ack = cpu_ack | grant[b][mem_pkg::CL_CPU];
			sp_rdata = sp_rdata | (grant[b][mem_pkg::CL_SPRITE] ? bank_dout[b] : '0);
			bg_rdata = bg_rdata | (grant[b][mem_pkg::CL_BG] ? bank_dout[b] : '0);
			cpu_rdata = cpu_rdata | (grant[b][mem_pkg::CL_CPU] ? bank_dout[b] : '0);
		end
	end

endmodule

`default_nettype wire

//--- hdl/memory_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memory_subsystem (
	input  wire                        CLK,
	input  wire                        RSTb,

	input  wire                        sp_req,
	input  wire  [mem_pkg::ADDR_W-1:0] sp_addr,
	output logic [mem_pkg::DATA_W-1:0] sp_rdata,
	output logic                       sp_ack,

	input  wire                        bg_req,
	input  wire  [mem_pkg::ADDR_W-1:0] bg_addr,
	output logic [mem_pkg::DATA_W-1:0] bg_rdata,
	output logic                       bg_ack,

	input  wire                        fl_req,
	input  wire  [mem_pkg::ADDR_W-1:0] fl_addr,
	input  wire  [mem_pkg::DATA_W-1:0] fl_wdata,
	output logic                       fl_ack,

	input  wire                        cpu_req,
	input  wire                        cpu_wr,
	input  wire  [mem_pkg::ADDR_W-1:0] cpu_addr,
	input  wire  [mem_pkg::DATA_W-1:0] cpu_wdata,
	output logic [mem_pkg::DATA_W-1:0] cpu_rdata,
	output logic                       cpu_ack
);

	logic [mem_pkg::BANK_ADDR_W-1:0] b1_addr;
	logic [mem_pkg::BANK_ADDR_W-1:0] b2_addr;
	logic [mem_pkg::BANK_ADDR_W-1:0] b3_addr;
	logic [mem_pkg::BANK_ADDR_W-1:0] b4_addr;
	logic [mem_pkg::DATA_W-1:0] b1_din;
	logic [mem_pkg::DATA_W-1:0] b2_din;
	logic [mem_pkg::DATA_W-1:0] b3_din;
	logic [mem_pkg::DATA_W-1:0] b4_din;
	logic b1_wr;
	logic b2_wr;
	logic b3_wr;
	logic b4_wr;
	logic [mem_pkg::DATA_W-1:0] b1_dout;
	logic [mem_pkg::DATA_W-1:0] b2_dout;
	logic [mem_pkg::DATA_W-1:0] b3_dout;
	logic [mem_pkg::DATA_W-1:0] b4_dout;

	memory_arbiter memory_arbiter_inst (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.sp_req    (sp_req),
		.sp_addr   (sp_addr),
		.sp_rdata  (sp_rdata),
		.sp_ack    (sp_ack),
		.bg_req    (bg_req),
		.bg_addr   (bg_addr),
		.bg_rdata  (bg_rdata),
		.bg_ack    (bg_ack),
		.fl_req    (fl_req),
		.fl_addr   (fl_addr),
		.fl_wdata  (fl_wdata),
		.fl_ack    (fl_ack),
		.cpu_req   (cpu_req),
		.cpu_wr    (cpu_wr),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_rdata (cpu_rdata),
		.cpu_ack   (cpu_ack),
		.b1_addr   (b1_addr),
		.b1_din    (b1_din),
		.b1_wr     (b1_wr),
		.b1_dout   (b1_dout),
		.b2_addr   (b2_addr),
		.b2_din    (b2_din),
		.b2_wr     (b2_wr),
		.b2_dout   (b2_dout),
		.b3_addr   (b3_addr),
		.b3_din    (b3_din),
		.b3_wr     (b3_wr),
		.b3_dout   (b3_dout),
		.b4_addr   (b4_addr),
		.b4_din    (b4_din),
		.b4_wr     (b4_wr),
		.b4_dout   (b4_dout)
	);

	// bank n holds addresses with addr[15:14] == n-1
	bank_ram bank_ram_1 (.CLK(CLK), .addr(b1_addr), .din(b1_din), .wr(b1_wr), .dout(b1_dout));
	bank_ram bank_ram_2 (.CLK(CLK), .addr(b2_addr), .din(b2_din), .wr(b2_wr), .dout(b2_dout));
	bank_ram bank_ram_3 (.CLK(CLK), .addr(b3_addr), .din(b3_din), .wr(b3_wr), .dout(b3_dout));
	bank_ram bank_ram_4 (.CLK(CLK), .addr(b4_addr), .din(b4_din), .wr(b4_wr), .dout(b4_dout));

endmodule

`default_nettype wire

//--- sim.f
hdl/mem_pkg.sv
hdl/bank_ram.sv
hdl/bank_arbiter.sv
hdl/memory_arbiter.sv
hdl/memory_subsystem.sv
sim/memory_arbiter_assert.sv
sim/memory_checker.sv
sim/tb_memory_subsystem.sv

//--- sim/memory_arbiter_assert.sv
`timescale 1ns/1ps
`default_nettype none

module memory_arbiter_assert (
	input wire                             CLK,
	input wire                             RSTb,
	input wire                             sp_req,
	input wire                             sp_ack,
	input wire                             bg_req,
	input wire                             bg_ack,
	input wire                             fl_req,
	input wire                             fl_ack,
	input wire                             cpu_req,
	input wire                             cpu_ack,
	input wire [mem_pkg::NUM_CLIENTS-1:0] grant0,
	input wire [mem_pkg::NUM_CLIENTS-1:0] grant1,
	input wire [mem_pkg::NUM_CLIENTS-1:0] grant2,
	input wire [mem_pkg::NUM_CLIENTS-1:0] grant3
);

	logic [3:0] req;
	logic [3:0] ack;

	assign req = {cpu_req, fl_req, bg_req, sp_req};
	assign ack = {cpu_ack, fl_ack, bg_ack, sp_ack};

	// a bank serves one client at a time
	a_grant_onehot: assert property (@(posedge CLK) disable iff (!RSTb)
		$onehot0(grant0) && $onehot0(grant1) && $onehot0(grant2) && $onehot0(grant3))
		else $error("bank grant vector has more than one bit set");

	a_reset_quiet: assert property (@(posedge CLK) !RSTb |=> ack == 4'b0000)
		else $error("ack high right after reset");

	a_ack_needs_req: assert property (@(posedge CLK) disable iff (!RSTb)
		(ack & ~$past(ack) & ~$past(req)) == 4'b0000)
		else $error("ack rose without a request");

	// a granted ack repeats req one cycle later
	a_ack_release: assert property (@(posedge CLK) disable iff (!RSTb)
		((ack ^ $past(req)) & $past(ack)) == 4'b0000)
		else $error("ack did not fall exactly one cycle after req fell");

endmodule

bind memory_arbiter memory_arbiter_assert memory_arbiter_assert_inst (
	.CLK     (CLK),
	.RSTb    (RSTb),
	.sp_req  (sp_req),
	.sp_ack  (sp_ack),
	.bg_req  (bg_req),
	.bg_ack  (bg_ack),
	.fl_req  (fl_req),
	.fl_ack  (fl_ack),
	.cpu_req (cpu_req),
	.cpu_ack (cpu_ack),
	.grant0  (grant[0]),
	.grant1  (grant[1]),
	.grant2  (grant[2]),
	.grant3  (grant[3])
);

`default_nettype wire

//--- sim/memory_checker.sv
`timescale 1ns/1ps
`default_nettype none

module memory_checker (
	input wire                        CLK,
	input wire                        RSTb,
	input wire                        uncontested,
	input wire                        sp_req,
	input wire [mem_pkg::ADDR_W-1:0] sp_addr,
	input wire [mem_pkg::DATA_W-1:0] sp_rdata,
	input wire                        sp_ack,
	input wire                        bg_req,
	input wire [mem_pkg::ADDR_W-1:0] bg_addr,
	input wire [mem_pkg::DATA_W-1:0] bg_rdata,
	input wire                        bg_ack,
	input wire                        fl_req,
	input wire [mem_pkg::ADDR_W-1:0] fl_addr,
	input wire                        fl_ack,
	input wire                        cpu_req,
	input wire                        cpu_wr,
	input wire [mem_pkg::ADDR_W-1:0] cpu_addr,
	input wire [mem_pkg::DATA_W-1:0] cpu_rdata,
	input wire                        cpu_ack
);

	int test_num = 0;
	int test_errors = 0;
	int check_total = 0;
	int error_total = 0;

	// per client in priority order
	logic req [4];
	logic ack [4];
	logic [1:0] bank [4];
	logic req_q [4];
	logic ack_q [4];
	logic [1:0] bank_q [4];
	// sampled cycles with req high and no ack yet
	int wait_cnt [4];
	string ack_name [4] = '{"sp_ack", "bg_ack", "fl_ack", "cpu_ack"};

	assign req[0] = sp_req;
	assign req[1] = bg_req;
	assign req[2] = fl_req;
	assign req[3] = cpu_req;
	assign ack[0] = sp_ack;
	assign ack[1] = bg_ack;
	assign ack[2] = fl_ack;
	assign ack[3] = cpu_ack;
	assign bank[0] = sp_addr[15:14];
	assign bank[1] = bg_addr[15:14];
	assign bank[2] = fl_addr[15:14];
	assign bank[3] = cpu_addr[15:14];

	task automatic count_error();
		test_errors++;
		error_total++;
	endtask

	task automatic report_fault(input string msg);
		$display("at %0t: %s", $time, msg);
		count_error();
	endtask

	task automatic compare_read(
		input string name,
		input logic [mem_pkg::ADDR_W-1:0] addr,
		input logic [mem_pkg::DATA_W-1:0] actual
	);
		logic [mem_pkg::DATA_W-1:0] expected;
		expected = tb_memory_subsystem.expected_word(addr);
		check_total++;
		if (actual !== expected) begin
			$display("** Error at %0t: %s expected %h got %h (addr %h)",
				$time, name, expected, actual, addr);
			count_error();
		end
	endtask

	// read data with its ack low
	task automatic compare_idle(
		input string name,
		input logic [mem_pkg::DATA_W-1:0] actual
	);
		logic [mem_pkg::DATA_W-1:0] expected;
		expected = '0;
		if (actual !== expected) begin
			$display("** Error at %0t: %s expected %h got %h", $time, name, expected, actual);
			count_error();
		end
	endtask

	// sampled on the rising edge where falling-edge drives are stable
	always @(posedge CLK) begin
		if (!RSTb) begin
			for (int c = 0; c < 4; c++) begin
				if (ack[c] !== 1'b0) begin
					report_fault($sformatf("%s is high during reset", ack_name[c]));
				end
				wait_cnt[c] = 0;
			end
		end else begin
			if (sp_ack) begin
				compare_read("sp_rdata", sp_addr, sp_rdata);
			end
			if (bg_ack) begin
				compare_read("bg_rdata", bg_addr, bg_rdata);
			end
			// write acks show the old word first
			if (cpu_ack && !cpu_wr) begin
				compare_read("cpu_rdata", cpu_addr, cpu_rdata);
			end
			for (int c = 0; c < 4; c++) begin
				if (ack[c] && !ack_q[c]) begin
					check_total++;
					if (uncontested && wait_cnt[c] != 1) begin
						$display("** Error at %0t: %s latency expected 1 got %0d",
							$time, ack_name[c], wait_cnt[c]);
						count_error();
					end
					// pick was made from the previous sample
					for (int h = 0; h < c; h++) begin
						if (req_q[h] && !ack_q[h] && bank_q[h] == bank_q[c]) begin
							report_fault($sformatf(
								"%s rose while %s was still waiting on bank %0d",
								ack_name[c], ack_name[h], bank_q[c]));
						end
					end
					wait_cnt[c] = 0;
				end else if (req[c] && !ack[c]) begin
					wait_cnt[c]++;
				end
				// once granted, ack copies req one cycle late
				if (ack_q[c] && ack[c] !== req_q[c]) begin
					report_fault($sformatf("%s did not fall exactly one cycle after req fell",
						ack_name[c]));
				end
			end
		end
		if (!sp_ack) begin
			compare_idle("sp_rdata", sp_rdata);
		end
		if (!bg_ack) begin
			compare_idle("bg_rdata", bg_rdata);
		end
		if (!cpu_ack) begin
			compare_idle("cpu_rdata", cpu_rdata);
		end
		for (int c = 0; c < 4; c++) begin
			req_q[c] = req[c];
			ack_q[c] = ack[c];
			bank_q[c] = bank[c];
		end
	end

	task automatic close_test(input string name);
		test_num++;
		$display("test %0d %s: %0d errors", test_num, name, test_errors);
		test_errors = 0;
	endtask

	task automatic print_summary();
		$display("%0d tests, %0d checks, %0d errors", test_num, check_total, error_total);
	endtask

endmodule

`default_nettype wire

//--- sim/tb_memory_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory_subsystem;

	localparam int N_FILL = 16;
	localparam int N_MIX = 32;
	localparam int N_PAIR = 8;
	localparam int N_ROUND = 4;
	// fill and readback, cpu mix, fetcher pairs, four-way rounds, timing probes
	localparam int NUM_XFERS = 2 * N_FILL + N_MIX + 2 * N_PAIR + 4 * N_ROUND + 5;
	localparam int TIMEOUT_CYCLES = NUM_XFERS * 20 + 200;

	logic CLK = 1'b0;
	logic RSTb;
	logic sp_req;
	logic [mem_pkg::ADDR_W-1:0] sp_addr;
	logic [mem_pkg::DATA_W-1:0] sp_rdata;
	logic sp_ack;
	logic bg_req;
	logic [mem_pkg::ADDR_W-1:0] bg_addr;
	logic [mem_pkg::DATA_W-1:0] bg_rdata;
	logic bg_ack;
	logic fl_req;
	logic [mem_pkg::ADDR_W-1:0] fl_addr;
	logic [mem_pkg::DATA_W-1:0] fl_wdata;
	logic fl_ack;
	logic cpu_req;
	logic cpu_wr;
	logic [mem_pkg::ADDR_W-1:0] cpu_addr;
	logic [mem_pkg::DATA_W-1:0] cpu_wdata;
	logic [mem_pkg::DATA_W-1:0] cpu_rdata;
	logic cpu_ack;
	logic uncontested;

	// indexed by client_e
	logic [mem_pkg::NUM_CLIENTS-1:0] ack_vec;
	// expected contents of the whole address space
	logic [mem_pkg::DATA_W-1:0] shadow [0:(1 << mem_pkg::ADDR_W)-1];
	logic [mem_pkg::ADDR_W-1:0] fill_addr [N_FILL];

	assign ack_vec = {cpu_ack, fl_ack, bg_ack, sp_ack};

	always #5 CLK = ~CLK;

	memory_subsystem memory_subsystem_inst (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.sp_req    (sp_req),
		.sp_addr   (sp_addr),
		.sp_rdata  (sp_rdata),
		.sp_ack    (sp_ack),
		.bg_req    (bg_req),
		.bg_addr   (bg_addr),
		.bg_rdata  (bg_rdata),
		.bg_ack    (bg_ack),
		.fl_req    (fl_req),
		.fl_addr   (fl_addr),
		.fl_wdata  (fl_wdata),
		.fl_ack    (fl_ack),
		.cpu_req   (cpu_req),
		.cpu_wr    (cpu_wr),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_rdata (cpu_rdata),
		.cpu_ack   (cpu_ack)
	);

	memory_checker memory_checker_inst (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.uncontested (uncontested),
		.sp_req      (sp_req),
		.sp_addr     (sp_addr),
		.sp_rdata    (sp_rdata),
		.sp_ack      (sp_ack),
		.bg_req      (bg_req),
		.bg_addr     (bg_addr),
		.bg_rdata    (bg_rdata),
		.bg_ack      (bg_ack),
		.fl_req      (fl_req),
		.fl_addr     (fl_addr),
		.fl_ack      (fl_ack),
		.cpu_req     (cpu_req),
		.cpu_wr      (cpu_wr),
		.cpu_addr    (cpu_addr),
		.cpu_rdata   (cpu_rdata),
		.cpu_ack     (cpu_ack)
	);

	// word a read of addr must return
	function automatic logic [mem_pkg::DATA_W-1:0] expected_word(
		input logic [mem_pkg::ADDR_W-1:0] addr
	);
		return shadow[addr];
	endfunction

	function automatic logic [mem_pkg::ADDR_W-1:0] random_addr(input logic [1:0] bank);
		return {bank, 14'($urandom)};
	endfunction

	// returns on the falling edge where ack has the given level
	task automatic wait_ack(input mem_pkg::client_e c, input logic level);
		do begin
			@(negedge CLK);
		end while (ack_vec[c] !== level);
	endtask

	task automatic sprite_read(input logic [mem_pkg::ADDR_W-1:0] addr);
		sp_addr = addr;
		sp_req = 1'b1;
		wait_ack(mem_pkg::CL_SPRITE, 1'b1);
		sp_req = 1'b0;
		wait_ack(mem_pkg::CL_SPRITE, 1'b0);
	endtask

	task automatic background_read(input logic [mem_pkg::ADDR_W-1:0] addr);
		bg_addr = addr;
		bg_req = 1'b1;
		wait_ack(mem_pkg::CL_BG, 1'b1);
		bg_req = 1'b0;
		wait_ack(mem_pkg::CL_BG, 1'b0);
	endtask

	task automatic flash_write(
		input logic [mem_pkg::ADDR_W-1:0] addr,
		input logic [mem_pkg::DATA_W-1:0] data
	);
		fl_addr = addr;
		fl_wdata = data;
		fl_req = 1'b1;
		wait_ack(mem_pkg::CL_FLASH, 1'b1);
		// write landed at the edge before ack rose
		shadow[addr] = data;
		fl_req = 1'b0;
		wait_ack(mem_pkg::CL_FLASH, 1'b0);
	endtask

	task automatic cpu_access(
		input logic wr,
		input logic [mem_pkg::ADDR_W-1:0] addr,
		input logic [mem_pkg::DATA_W-1:0] data
	);
		cpu_wr = wr;
		cpu_addr = addr;
		cpu_wdata = data;
		cpu_req = 1'b1;
		wait_ack(mem_pkg::CL_CPU, 1'b1);
		if (wr) begin
			shadow[addr] = data;
		end
		cpu_req = 1'b0;
		wait_ack(mem_pkg::CL_CPU, 1'b0);
	endtask

	initial begin
		logic [mem_pkg::ADDR_W-1:0] shared;
		void'($urandom(32'h7ffa));
		RSTb = 1'b0;
		sp_req = 1'b0;
		sp_addr = '0;
		bg_req = 1'b0;
		bg_addr = '0;
		fl_req = 1'b0;
		fl_addr = '0;
		fl_wdata = '0;
		cpu_req = 1'b0;
		cpu_wr = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		uncontested = 1'b0;
		for (int i = 0; i < (1 << mem_pkg::ADDR_W); i++) begin
			shadow[i] = '0;
		end
		repeat (2) @(negedge CLK);
		RSTb = 1'b1;
		@(negedge CLK);

		// fill address i lands in bank i mod 4
		for (int i = 0; i < N_FILL; i++) begin
			fill_addr[i] = random_addr(2'(i));
			flash_write(fill_addr[i], 16'($urandom));
		end
		for (int i = 0; i < N_FILL; i++) begin
			cpu_access(1'b0, fill_addr[i], '0);
		end
		memory_checker_inst.close_test("flash fill, cpu readback");

		// small window per bank so reads see both written and fresh words
		for (int i = 0; i < N_MIX; i++) begin
			cpu_access(1'($urandom), {2'(i), 10'h15a, 4'($urandom)}, 16'($urandom));
		end
		memory_checker_inst.close_test("cpu write/read mix");

		// each fetcher alone on its bank sees the one-cycle latency
		uncontested = 1'b1;
		for (int i = 0; i < N_PAIR; i++) begin
			fork
				sprite_read(fill_addr[i]);
				background_read(fill_addr[i + 1]);
			join
		end
		uncontested = 1'b0;
		memory_checker_inst.close_test("fetchers on different banks");

		// all four clients on bank r in the same cycle
		for (int r = 0; r < N_ROUND; r++) begin
			shared = random_addr(2'(r));
			fork
				sprite_read(fill_addr[r]);
				background_read(fill_addr[r + 4]);
				flash_write(shared, 16'($urandom));
				cpu_access(1'b0, shared, '0);
			join
		end
		memory_checker_inst.close_test("four clients on one bank");

		// sprite request held through reset waits for the release
		uncontested = 1'b1;
		sp_addr = fill_addr[0];
		sp_req = 1'b1;
		RSTb = 1'b0;
		repeat (2) @(negedge CLK);
		RSTb = 1'b1;
		wait_ack(mem_pkg::CL_SPRITE, 1'b1);
		sp_req = 1'b0;
		wait_ack(mem_pkg::CL_SPRITE, 1'b0);
		background_read(fill_addr[1]);
		flash_write(16'h3ff0, 16'hbeef);
		cpu_access(1'b1, 16'hc001, 16'h1234);
		cpu_access(1'b0, 16'hc001, '0);
		uncontested = 1'b0;
		memory_checker_inst.close_test("uncontested timing and reset");

		memory_checker_inst.print_summary();
		if (memory_checker_inst.error_total == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge CLK);
		$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
